// File: cpu_axi_bridge.f
axi_pkg.sv
bridge_pkg.sv
bridge_ctrl.sv
axi_read_chan.sv
axi_write_chan.sv
cpu_axi_bridge.sv
tb_clk_gen.sv
axi_mem_model.sv
cpu_axi_bridge_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := cpu_axi_bridge_tb
FILELIST := cpu_axi_bridge.f
OBJ_DIR  := obj_dir
PASS_MSG := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: cpu_axi_bridge_tb.sv
`timescale 1ns/100ps

module cpu_axi_bridge_tb;

   localparam axi_pkg::addr_t ERR_BASE = 32'h8000_0000;
   localparam int             TIMEOUT  = 200;

   typedef enum int {
      W_RESET,
      W_INST_ADDR_OK,
      W_INST_VALID,
      W_DATA_ADDR_OK,
      W_DATA_OK
   } wait_e;

   logic                 aclk;
   logic                 arst_n;
   logic                 inst_req;
   axi_pkg::addr_t       inst_addr;
   logic                 inst_addr_ok;
   logic                 inst_valid;
   bridge_pkg::cpu_rsp_t inst_rsp;
   logic                 data_req;
   logic                 data_wr;
   bridge_pkg::cpu_req_t data_req_bus;
   logic                 data_addr_ok;
   logic                 data_data_ok;
   bridge_pkg::cpu_rsp_t data_rsp;
   axi_pkg::axi_addr_t   ar;
   logic                 arvalid;
   logic                 arready;
   axi_pkg::axi_r_t      r;
   logic                 rvalid;
   logic                 rready;
   axi_pkg::axi_addr_t   aw;
   logic                 awvalid;
   logic                 awready;
   axi_pkg::axi_w_t      w;
   logic                 wvalid;
   logic                 wready;
   axi_pkg::axi_b_t      b;
   logic                 bvalid;
   logic                 bready;

   // reference memory and expected responses
   axi_pkg::data_t       ref_mem [0:255];
   int                   seed = 54;
   int                   errors = 0;
   bridge_pkg::cpu_rsp_t exp_inst;
   bridge_pkg::cpu_rsp_t exp_data;
   logic                 exp_data_rd;
   axi_pkg::addr_t       exp_ar_addr;
   bridge_pkg::cpu_req_t exp_store;
   // transaction tracking
   logic                 seen_req;
   int                   pending;
   logic                 pend_fetch;

   tb_clk_gen u_clk (
      .clk    (aclk),
      .arst_n (arst_n)
   );

   cpu_axi_bridge dut (.*);

   axi_mem_model #(.ERR_BASE(ERR_BASE)) u_mem (.*);

   task automatic value_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic timeout_fail(input string what);
      errors++;
      $display("timed out waiting for %s", what);
      $display(">>> FAIL");
      $fatal(1, "timeout");
   endtask

   // accepts and ok pulses counted at the clock
   always @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         seen_req   <= 1'b0;
         pending    <= 0;
         pend_fetch <= 1'b0;
      end else begin
         if (inst_req || data_req) begin
            seen_req <= 1'b1;
         end
         if ((inst_addr_ok || data_addr_ok) && !(inst_valid || data_data_ok)) begin
            pending <= pending + 1;
         end else if (!(inst_addr_ok || data_addr_ok) && (inst_valid || data_data_ok)) begin
            pending <= pending - 1;
         end
         if (inst_addr_ok || data_addr_ok) begin
            pend_fetch <= inst_addr_ok;
         end
      end
   end

   // quiet bus until the first request
   a_quiet: assert property (@(posedge aclk) disable iff (!arst_n)
      (!seen_req && !inst_req && !data_req) |-> !(arvalid || awvalid || wvalid || rready ||
         bready || inst_addr_ok || data_addr_ok || inst_valid || data_data_ok))
      else value_error("bus activity before the first request");
   // one transaction in flight
   a_accept: assert property (@(posedge aclk) disable iff (!arst_n)
      (inst_addr_ok || data_addr_ok) |-> (pending == 0 || inst_valid || data_data_ok))
      else value_error("addr_ok with a transaction still open");
   a_ok_once: assert property (@(posedge aclk) disable iff (!arst_n)
      (inst_valid || data_data_ok) |-> (pending == 1 && !(inst_valid && data_data_ok)))
      else value_error("ok pulse without an open transaction");
   a_inst_port: assert property (@(posedge aclk) disable iff (!arst_n)
      inst_valid |-> pend_fetch)
      else value_error("inst_valid for a data request");
   a_data_port: assert property (@(posedge aclk) disable iff (!arst_n)
      data_data_ok |-> !pend_fetch)
      else value_error("data_data_ok for a fetch");
   a_inst_rsp: assert property (@(posedge aclk) disable iff (!arst_n)
      inst_valid |-> (inst_rsp.bus_err == exp_inst.bus_err &&
         (exp_inst.bus_err || inst_rsp.rdata == exp_inst.rdata)))
      else value_error("fetch response differs from reference");
   a_data_rsp: assert property (@(posedge aclk) disable iff (!arst_n)
      data_data_ok |-> (data_rsp.bus_err == exp_data.bus_err &&
         (exp_data.bus_err || !exp_data_rd || data_rsp.rdata == exp_data.rdata)))
      else value_error("data response differs from reference");
   // store wins over fetch
   a_prio: assert property (@(posedge aclk) disable iff (!arst_n)
      inst_addr_ok |-> !data_req)
      else value_error("inst_addr_ok while data_req pending");
   // valid and payload held through stalls
   a_ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
      (arvalid && !arready) |=> (arvalid && $stable(ar)))
      else value_error("AR dropped or changed before arready");
   a_aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
      (awvalid && !awready) |=> (awvalid && $stable(aw)))
      else value_error("AW dropped or changed before awready");
   a_w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
      (wvalid && !wready) |=> (wvalid && $stable(w)))
      else value_error("W dropped or changed before wready");
   // single beat of 4 bytes, INCR burst
   a_ar_fields: assert property (@(posedge aclk) disable iff (!arst_n)
      arvalid |-> (ar.size == 3'd2 && ar.len == 4'd0 &&
         ar.burst == 2'd1 && ar.addr == exp_ar_addr))
      else value_error("wrong AR payload");
   a_aw_fields: assert property (@(posedge aclk) disable iff (!arst_n)
      awvalid |-> (aw.size == 3'd2 && aw.len == 4'd0 &&
         aw.burst == 2'd1 && aw.addr == exp_store.addr))
      else value_error("wrong AW payload");
   a_w_fields: assert property (@(posedge aclk) disable iff (!arst_n)
      wvalid |-> (w.last && w.data == exp_store.wdata && w.strb == exp_store.wstrb))
      else value_error("wrong W payload");
   // response readies only while their transfer is open
   a_bready: assert property (@(posedge aclk) disable iff (!arst_n)
      bready |-> (!awvalid && !wvalid && pending == 1))
      else value_error("bready before AW and W completed");
   a_rready: assert property (@(posedge aclk) disable iff (!arst_n)
      rready |-> (pending == 1))
      else value_error("rready with no read open");

   task automatic next_cycle();
      @(posedge aclk);
      #1;
   endtask

   // strobes sampled at the falling edge
   task automatic wait_for(input wait_e which, input string what);
      int   cycles;
      logic hit;
      cycles = 0;
      hit    = 1'b0;
      while (!hit) begin
         @(negedge aclk);
         case (which)
            W_RESET:        hit = arst_n;
            W_INST_ADDR_OK: hit = inst_addr_ok;
            W_INST_VALID:   hit = inst_valid;
            W_DATA_ADDR_OK: hit = data_addr_ok;
            default:        hit = data_data_ok;
         endcase
         cycles++;
         if (!hit && cycles >= TIMEOUT) begin
            timeout_fail(what);
         end
      end
   endtask

   function automatic axi_pkg::data_t fill_word(input logic [7:0] idx);
      return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
   endfunction

   function automatic axi_pkg::addr_t rand_addr();
      logic [7:0] idx;
      idx = 8'($random(seed));
      return {22'd0, idx, 2'b00};
   endfunction

   function automatic bridge_pkg::cpu_req_t make_store(input axi_pkg::addr_t addr);
      bridge_pkg::cpu_req_t req;
      req.addr  = addr;
      req.wdata = $random(seed);
      req.wstrb = 4'($random(seed));
      return req;
   endfunction

   function automatic bridge_pkg::cpu_req_t make_load(input axi_pkg::addr_t addr);
      bridge_pkg::cpu_req_t req;
      req.addr  = addr;
      req.wdata = '0;
      req.wstrb = '0;
      return req;
   endfunction

   task automatic set_fetch(input axi_pkg::addr_t addr);
      exp_inst.bus_err = (addr >= ERR_BASE);
      exp_inst.rdata   = ref_mem[addr[9:2]];
      exp_ar_addr      = addr;
   endtask

   task automatic set_load(input axi_pkg::addr_t addr);
      exp_data.bus_err = (addr >= ERR_BASE);
      exp_data.rdata   = ref_mem[addr[9:2]];
      exp_data_rd      = 1'b1;
      exp_ar_addr      = addr;
   endtask

   // new bytes merged over the old word per strobe
   task automatic set_store(input bridge_pkg::cpu_req_t req);
      exp_store        = req;
      exp_data.bus_err = (req.addr >= ERR_BASE);
      exp_data.rdata   = '0;
      exp_data_rd      = 1'b0;
      if (req.addr < ERR_BASE) begin
         for (int i = 0; i < 4; i++) begin
            if (req.wstrb[i]) begin
               ref_mem[req.addr[9:2]][8*i +: 8] = req.wdata[8*i +: 8];
            end
         end
      end
   endtask

   task automatic fetch_word(input axi_pkg::addr_t addr);
      next_cycle();
      set_fetch(addr);
      inst_req  = 1'b1;
      inst_addr = addr;
      wait_for(W_INST_ADDR_OK, "inst_addr_ok");
      next_cycle();
      inst_req = 1'b0;
      wait_for(W_INST_VALID, "inst_valid");
   endtask

   task automatic data_access(input logic wr, input bridge_pkg::cpu_req_t req);
      next_cycle();
      if (wr) begin
         set_store(req);
      end else begin
         set_load(req.addr);
      end
      data_req     = 1'b1;
      data_wr      = wr;
      data_req_bus = req;
      wait_for(W_DATA_ADDR_OK, "data_addr_ok");
      next_cycle();
      data_req = 1'b0;
      wait_for(W_DATA_OK, "data_data_ok");
   endtask

   // fetch is accepted in the cycle of the store ok pulse
   task automatic dual_request(input bridge_pkg::cpu_req_t st, input axi_pkg::addr_t fa);
      next_cycle();
      set_store(st);
      set_fetch(fa);
      inst_req     = 1'b1;
      inst_addr    = fa;
      data_req     = 1'b1;
      data_wr      = 1'b1;
      data_req_bus = st;
      wait_for(W_DATA_ADDR_OK, "data_addr_ok");
      next_cycle();
      data_req = 1'b0;
      wait_for(W_INST_ADDR_OK, "inst_addr_ok");
      next_cycle();
      inst_req = 1'b0;
      wait_for(W_INST_VALID, "inst_valid");
   endtask

   initial begin
      axi_pkg::addr_t addr;
      inst_req     = 1'b0;
      inst_addr    = '0;
      data_req     = 1'b0;
      data_wr      = 1'b0;
      data_req_bus = '0;
      exp_inst     = '0;
      exp_data     = '0;
      exp_data_rd  = 1'b0;
      exp_ar_addr  = '0;
      exp_store    = '0;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = fill_word(8'(i));
      end
      wait_for(W_RESET, "reset release");
      // idle cycles with no request
      repeat (5) next_cycle();
      for (int i = 0; i < 8; i++) begin
         fetch_word(rand_addr());
      end
      // store then load back, then fetch the same word
      for (int i = 0; i < 16; i++) begin
         addr = rand_addr();
         data_access(1'b1, make_store(addr));
         data_access(1'b0, make_load(addr));
         fetch_word(addr);
      end
      // both ports in one cycle
      // fetch goes to the next word
      for (int i = 0; i < 4; i++) begin
         addr = rand_addr();
         dual_request(make_store(addr), {22'd0, addr[9:2] + 8'd1, 2'b00});
      end
      // error region
      fetch_word(ERR_BASE + 32'h40);
      data_access(1'b0, make_load(32'hffff_fffc));
      data_access(1'b1, make_store(ERR_BASE));
      data_access(1'b1, make_store(32'hc000_1000));
      // normal traffic afterwards
      addr = rand_addr();
      data_access(1'b1, make_store(addr));
      data_access(1'b0, make_load(addr));
      fetch_word(rand_addr());
      repeat (4) next_cycle();
      if (errors == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display(">>> FAIL");
         $fatal(1, "checks failed");
      end
   end

endmodule

// File: axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model #(
   parameter axi_pkg::addr_t ERR_BASE = 32'h8000_0000
) (
   input  logic               aclk,
   input  logic               arst_n,
   input  axi_pkg::axi_addr_t ar,
   input  logic               arvalid,
   output logic               arready,
   output axi_pkg::axi_r_t    r,
   output logic               rvalid,
   input  logic               rready,
   input  axi_pkg::axi_addr_t aw,
   input  logic               awvalid,
   output logic               awready,
   input  axi_pkg::axi_w_t    w,
   input  logic               wvalid,
   output logic               wready,
   output axi_pkg::axi_b_t    b,
   output logic               bvalid,
   input  logic               bready
);

   axi_pkg::data_t mem [0:255];
   int             seed = 54;
   // read side
   axi_pkg::addr_t rd_addr_q;
   logic           rd_pend;
   int             rd_wait;
   // write side
   axi_pkg::addr_t wr_addr_q;
   axi_pkg::data_t wr_data_q;
   axi_pkg::strb_t wr_strb_q;
   logic           aw_got;
   logic           w_got;
   int             wr_wait;

   // one process so the random sequence has a fixed order
   always @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         // word pattern built from the whole word index
         for (int i = 0; i < 256; i++) begin
            mem[i] <= {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i) + 8'h3c};
         end
         arready   <= 1'b0;
         rvalid    <= 1'b0;
         r         <= '0;
         rd_pend   <= 1'b0;
         rd_wait   <= 0;
         rd_addr_q <= '0;
         awready   <= 1'b0;
         wready    <= 1'b0;
         bvalid    <= 1'b0;
         b         <= '0;
         aw_got    <= 1'b0;
         w_got     <= 1'b0;
         wr_wait   <= 0;
         wr_addr_q <= '0;
         wr_data_q <= '0;
         wr_strb_q <= '0;
      end else begin
         // ready is a one-cycle offer, stalls about one cycle in four
         arready <= 1'b0;
         if (arvalid && arready) begin
            rd_pend   <= 1'b1;
            rd_addr_q <= ar.addr;
            rd_wait   <= $random(seed) & 3;
         end else if (rd_pend && !rvalid) begin
            if (rd_wait == 0) begin
               rvalid <= 1'b1;
               r.id   <= axi_pkg::AR_ID;
               r.last <= 1'b1;
               // SLVERR above the error base
               if (rd_addr_q >= ERR_BASE) begin
                  r.data <= '0;
                  r.resp <= 2'b10;
               end else begin
                  r.data <= mem[rd_addr_q[9:2]];
                  r.resp <= 2'b00;
               end
            end else begin
               rd_wait <= rd_wait - 1;
            end
         end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            rd_pend <= 1'b0;
         end else if (!rd_pend) begin
            arready <= ($random(seed) & 3) != 0;
         end

         // AW and W accepted in any order
         awready <= 1'b0;
         wready  <= 1'b0;
         if (awvalid && awready) begin
            aw_got    <= 1'b1;
            wr_addr_q <= aw.addr;
            wr_wait   <= $random(seed) & 3;
         end else if (!aw_got && !bvalid) begin
            awready <= ($random(seed) & 3) != 0;
         end
         if (wvalid && wready) begin
            w_got     <= 1'b1;
            wr_data_q <= w.data;
            wr_strb_q <= w.strb;
         end else if (!w_got && !bvalid) begin
            wready <= ($random(seed) & 3) != 0;
         end
         if (aw_got && w_got && !bvalid) begin
            if (wr_wait == 0) begin
               bvalid <= 1'b1;
               b.id   <= axi_pkg::AW_ID;
               b.resp <= (wr_addr_q >= ERR_BASE) ? 2'b10 : 2'b00;
               aw_got <= 1'b0;
               w_got  <= 1'b0;
               // byte lanes written per strobe
               if (wr_addr_q < ERR_BASE) begin
                  for (int i = 0; i < 4; i++) begin
                     if (wr_strb_q[i]) begin
                        mem[wr_addr_q[9:2]][8*i +: 8] <= wr_data_q[8*i +: 8];
                     end
                  end
               end
            end else begin
               wr_wait <= wr_wait - 1;
            end
         end else if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
      end
   end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset held over the first two rising edges
   initial begin
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

// File: cpu_axi_bridge.sv
`timescale 1ns/100ps

module cpu_axi_bridge (
   input  logic                  aclk,
   input  logic                  arst_n,
   // fetch port
   input  logic                  inst_req,
   input  axi_pkg::addr_t        inst_addr,
   output logic                  inst_addr_ok,
   output logic                  inst_valid,
   output bridge_pkg::cpu_rsp_t  inst_rsp,
   // data port
   input  logic                  data_req,
   input  logic                  data_wr,
   input  bridge_pkg::cpu_req_t  data_req_bus,
   output logic                  data_addr_ok,
   output logic                  data_data_ok,
   output bridge_pkg::cpu_rsp_t  data_rsp,
   // AXI3 read
   output axi_pkg::axi_addr_t    ar,
   output logic                  arvalid,
   input  logic                  arready,
   input  axi_pkg::axi_r_t       r,
   input  logic                  rvalid,
   output logic                  rready,
   // AXI3 write
   output axi_pkg::axi_addr_t    aw,
   output logic                  awvalid,
   input  logic                  awready,
   output axi_pkg::axi_w_t       w,
   output logic                  wvalid,
   input  logic                  wready,
   input  axi_pkg::axi_b_t       b,
   input  logic                  bvalid,
   output logic                  bready
);

   // controller to read channel
   logic                 rd_start;
   axi_pkg::addr_t       rd_addr;
   logic                 busy_rd;
   logic                 rd_done;
   bridge_pkg::cpu_rsp_t rd_rsp;
   // controller to write channel
   logic                 wr_start;
   bridge_pkg::cpu_req_t wr_req;
   logic                 wr_done;
   bridge_pkg::cpu_rsp_t wr_rsp;

   bridge_ctrl u_ctrl (
      .aclk         (aclk),
      .arst_n       (arst_n),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .inst_addr_ok (inst_addr_ok),
      .inst_valid   (inst_valid),
      .inst_rsp     (inst_rsp),
      .data_req     (data_req),
      .data_wr      (data_wr),
      .data_req_bus (data_req_bus),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rsp     (data_rsp),
      .rd_start     (rd_start),
      .rd_addr      (rd_addr),
      .busy_rd      (busy_rd),
      .rd_done      (rd_done),
      .rd_rsp       (rd_rsp),
      .wr_start     (wr_start),
      .wr_req       (wr_req),
      .wr_done      (wr_done),
      .wr_rsp       (wr_rsp)
   );

   axi_read_chan u_rd (
      .aclk     (aclk),
      .arst_n   (arst_n),
      .rd_start (rd_start),
      .rd_addr  (rd_addr),
      .busy_rd  (busy_rd),
      .ar       (ar),
      .arvalid  (arvalid),
      .arready  (arready),
      .r        (r),
      .rvalid   (rvalid),
      .rready   (rready),
      .rd_done  (rd_done),
      .rd_rsp   (rd_rsp)
   );

   axi_write_chan u_wr (
      .aclk     (aclk),
      .arst_n   (arst_n),
      .wr_start (wr_start),
      .wr_req   (wr_req),
      .aw       (aw),
      .awvalid  (awvalid),
      .awready  (awready),
      .w        (w),
      .wvalid   (wvalid),
      .wready   (wready),
      .b        (b),
      .bvalid   (bvalid),
      .bready   (bready),
      .wr_done  (wr_done),
      .wr_rsp   (wr_rsp)
   );

endmodule

// File: axi_write_chan.sv
`timescale 1ns/100ps

module axi_write_chan (
   input  logic                  aclk,
   input  logic                  arst_n,
   // from controller
   input  logic                  wr_start,
   input  bridge_pkg::cpu_req_t  wr_req,
   // AW channel
   output axi_pkg::axi_addr_t    aw,
   output logic                  awvalid,
   input  logic                  awready,
   // W channel
   output axi_pkg::axi_w_t       w,
   output logic                  wvalid,
   input  logic                  wready,
   // B channel
   input  axi_pkg::axi_b_t       b,
   input  logic                  bvalid,
   output logic                  bready,
   // back to controller
   output logic                  wr_done,
   output bridge_pkg::cpu_rsp_t  wr_rsp
);

   bridge_pkg::cpu_req_t req_q;
   logic                 awvalid_q;
   logic                 wvalid_q;
   // handshake seen on each channel
   logic                 aw_sent_q;
   logic                 w_sent_q;

   // address, data and strobe for the whole write
   always_ff @(posedge aclk) begin
      if (wr_start) begin
         req_q <= wr_req;
      end
   end

   // AW and W run independently
   // the slave may take either one first
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
         aw_sent_q <= 1'b0;
         w_sent_q  <= 1'b0;
      end else if (wr_start) begin
         awvalid_q <= 1'b1;
         wvalid_q  <= 1'b1;
         aw_sent_q <= 1'b0;
         w_sent_q  <= 1'b0;
      end else if (wr_done) begin
         // write response closes the transaction
         aw_sent_q <= 1'b0;
         w_sent_q  <= 1'b0;
      end else begin
         if (awvalid_q && awready) begin
            awvalid_q <= 1'b0;
            aw_sent_q <= 1'b1;
         end
         if (wvalid_q && wready) begin
            wvalid_q <= 1'b0;
            w_sent_q <= 1'b1;
         end
      end
   end

   // fixed single-beat word write
   always_comb begin
      aw.id    = axi_pkg::AW_ID;
      aw.addr  = req_q.addr;
      aw.len   = axi_pkg::BEAT_LEN;
      aw.size  = axi_pkg::BEAT_SIZE;
      aw.burst = axi_pkg::BURST_INCR;
      aw.lock  = axi_pkg::LOCK_NORMAL;
      aw.cache = axi_pkg::CACHE_NONE;
      aw.prot  = axi_pkg::PROT_NONE;
   end

   // only beat is also the last
   assign w.data = req_q.wdata;
   assign w.strb = req_q.wstrb;
   assign w.last = 1'b1;

   assign awvalid = awvalid_q;
   assign wvalid  = wvalid_q;

   // response only once address and data are both through
   assign bready  = aw_sent_q & w_sent_q;
   assign wr_done = bvalid & bready;

   // stores return no data
   assign wr_rsp.rdata   = '0;
   assign wr_rsp.bus_err = (b.resp != axi_pkg::RESP_OKAY);

endmodule

// File: axi_read_chan.sv
`timescale 1ns/100ps

module axi_read_chan (
   input  logic                  aclk,
   input  logic                  arst_n,
   // from controller
   input  logic                  rd_start,
   input  axi_pkg::addr_t        rd_addr,
   input  logic                  busy_rd,
   // AR channel
   output axi_pkg::axi_addr_t    ar,
   output logic                  arvalid,
   input  logic                  arready,
   // R channel
   input  axi_pkg::axi_r_t       r,
   input  logic                  rvalid,
   output logic                  rready,
   // back to controller
   output logic                  rd_done,
   output bridge_pkg::cpu_rsp_t  rd_rsp
);

   axi_pkg::addr_t araddr_q;
   logic           arvalid_q;

   // address held for the whole AR handshake
   always_ff @(posedge aclk) begin
      if (rd_start) begin
         araddr_q <= rd_addr;
      end
   end

   // rd_start     _-____
   // arvalid_q    __--__
   // arready      ___-__
   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         arvalid_q <= 1'b0;
      end else if (rd_start) begin
         arvalid_q <= 1'b1;
      end else if (arvalid_q && arready) begin
         arvalid_q <= 1'b0;
      end
   end

   // fixed single-beat word read
   always_comb begin
      ar.id    = axi_pkg::AR_ID;
      ar.addr  = araddr_q;
      ar.len   = axi_pkg::BEAT_LEN;
      ar.size  = axi_pkg::BEAT_SIZE;
      ar.burst = axi_pkg::BURST_INCR;
      ar.lock  = axi_pkg::LOCK_NORMAL;
      ar.cache = axi_pkg::CACHE_NONE;
      ar.prot  = axi_pkg::PROT_NONE;
   end

   assign arvalid = arvalid_q;

   // accept read data only while a read is outstanding
   assign rready = busy_rd;

   // single beat so the first R handshake ends the transfer
   assign rd_done = rvalid & rready;

   // SLVERR and DECERR both map to a bus error
   assign rd_rsp.rdata   = r.data;
   assign rd_rsp.bus_err = (r.resp != axi_pkg::RESP_OKAY);

endmodule

// File: bridge_ctrl.sv
`timescale 1ns/100ps

module bridge_ctrl (
   input  logic                  aclk,
   input  logic                  arst_n,
   // fetch port
   input  logic                  inst_req,
   input  axi_pkg::addr_t        inst_addr,
   output logic                  inst_addr_ok,
   output logic                  inst_valid,
   output bridge_pkg::cpu_rsp_t  inst_rsp,
   // data port
   input  logic                  data_req,
   input  logic                  data_wr,
   input  bridge_pkg::cpu_req_t  data_req_bus,
   output logic                  data_addr_ok,
   output logic                  data_data_ok,
   output bridge_pkg::cpu_rsp_t  data_rsp,
   // read channel
   output logic                  rd_start,
   output axi_pkg::addr_t        rd_addr,
   output logic                  busy_rd,
   input  logic                  rd_done,
   input  bridge_pkg::cpu_rsp_t  rd_rsp,
   // write channel
   output logic                  wr_start,
   output bridge_pkg::cpu_req_t  wr_req,
   input  logic                  wr_done,
   input  bridge_pkg::cpu_rsp_t  wr_rsp
);

   bridge_pkg::bridge_state_e state_q;
   bridge_pkg::bridge_state_e state_d;
   bridge_pkg::xfer_kind_e    kind_q;
   bridge_pkg::xfer_kind_e    kind_d;
   logic                      idle;
   logic                      accept;
   logic                      fin;
   bridge_pkg::cpu_rsp_t      fin_rsp;

   // grant only while nothing is in flight
   assign idle = (state_q == bridge_pkg::ST_IDLE);

   // store beats load beats fetch
   // any data request masks the fetch port
   assign data_addr_ok = idle & data_req;
   assign inst_addr_ok = idle & inst_req & ~data_req;
   assign accept       = data_addr_ok | inst_addr_ok;

   always_comb begin
      if (data_req) begin
         kind_d = data_wr ? bridge_pkg::XFER_STORE : bridge_pkg::XFER_LOAD;
      end else begin
         kind_d = bridge_pkg::XFER_FETCH;
      end
   end

   // done pulse from whichever channel is active
   assign fin = ((state_q == bridge_pkg::ST_READ_BUSY) & rd_done) |
                ((state_q == bridge_pkg::ST_WRITE_BUSY) & wr_done);
   assign fin_rsp = (state_q == bridge_pkg::ST_WRITE_BUSY) ? wr_rsp : rd_rsp;

   always_comb begin
      state_d = state_q;
      case (state_q)
         bridge_pkg::ST_IDLE: begin
            if (accept) begin
               state_d = (kind_d == bridge_pkg::XFER_STORE) ? bridge_pkg::ST_WRITE_BUSY
                                                            : bridge_pkg::ST_READ_BUSY;
            end
         end
         bridge_pkg::ST_READ_BUSY: begin
            if (rd_done) begin
               state_d = bridge_pkg::ST_IDLE;
            end
         end
         bridge_pkg::ST_WRITE_BUSY: begin
            if (wr_done) begin
               state_d = bridge_pkg::ST_IDLE;
            end
         end
         default: state_d = bridge_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         state_q      <= bridge_pkg::ST_IDLE;
         kind_q       <= bridge_pkg::XFER_FETCH;
         rd_start     <= 1'b0;
         wr_start     <= 1'b0;
         inst_valid   <= 1'b0;
         data_data_ok <= 1'b0;
      end else begin
         state_q  <= state_d;
         // start pulses are one cycle after addr_ok
         rd_start <= accept & (kind_d != bridge_pkg::XFER_STORE);
         wr_start <= accept & (kind_d == bridge_pkg::XFER_STORE);
         if (accept) begin
            kind_q <= kind_d;
         end
         // ok pulse lands on the same edge that returns to idle
         inst_valid   <= fin & (kind_q == bridge_pkg::XFER_FETCH);
         data_data_ok <= fin & (kind_q != bridge_pkg::XFER_FETCH);
      end
   end

   // payload registers
   always_ff @(posedge aclk) begin
      if (accept) begin
         rd_addr <= data_req ? data_req_bus.addr : inst_addr;
      end
      if (accept && kind_d == bridge_pkg::XFER_STORE) begin
         wr_req <= data_req_bus;
      end
      if (fin && kind_q == bridge_pkg::XFER_FETCH) begin
         inst_rsp <= fin_rsp;
      end
      if (fin && kind_q != bridge_pkg::XFER_FETCH) begin
         data_rsp <= fin_rsp;
      end
   end

   // opens rready in the read channel
   assign busy_rd = (state_q == bridge_pkg::ST_READ_BUSY);

endmodule

// File: bridge_pkg.sv
package bridge_pkg;

   // data port request payload
   // held by the core until addr_ok
   typedef struct packed {
      axi_pkg::addr_t addr;
      axi_pkg::data_t wdata;
      // byte enables, bit 0 is the lowest byte lane
      axi_pkg::strb_t wstrb;
   } cpu_req_t;

   // response returned with the ok pulse
   typedef struct packed {
      // read word, zero for stores
      axi_pkg::data_t rdata;
      // any non-OKAY AXI response
      logic           bus_err;
   } cpu_rsp_t;

   // which port won the grant
   typedef enum logic [1:0] {
      XFER_FETCH = 2'd0,
      XFER_LOAD  = 2'd1,
      XFER_STORE = 2'd2
   } xfer_kind_e;

   // transaction state
   // read_busy covers both fetch and load
   typedef enum logic [1:0] {
      ST_IDLE       = 2'd0,
      ST_READ_BUSY  = 2'd1,
      ST_WRITE_BUSY = 2'd2
   } bridge_state_e;

endpackage

// File: axi_pkg.sv
package axi_pkg;

   // field widths of the AXI3 master port
   localparam int unsigned ADDR_W  = 32;
   localparam int unsigned DATA_W  = 32;
   localparam int unsigned STRB_W  = DATA_W / 8;
   localparam int unsigned RESP_W  = 2;
   localparam int unsigned ID_W    = 4;
   localparam int unsigned LEN_W   = 4;
   localparam int unsigned SIZE_W  = 3;
   localparam int unsigned BURST_W = 2;
   localparam int unsigned LOCK_W  = 2;
   localparam int unsigned CACHE_W = 4;
   localparam int unsigned PROT_W  = 3;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [STRB_W-1:0]  strb_t;
   typedef logic [RESP_W-1:0]  resp_t;
   typedef logic [ID_W-1:0]    id_t;
   typedef logic [LEN_W-1:0]   len_t;
   typedef logic [SIZE_W-1:0]  size_t;
   typedef logic [BURST_W-1:0] burst_t;
   typedef logic [LOCK_W-1:0]  lock_t;
   typedef logic [CACHE_W-1:0] cache_t;
   typedef logic [PROT_W-1:0]  prot_t;

   // single outstanding transaction so one id per direction
   localparam id_t    AR_ID       = '0;
   localparam id_t    AW_ID       = '0;
   // one beat per burst, AXI3 len counts beats minus one
   localparam len_t   BEAT_LEN    = '0;
   // 4 bytes per beat
   localparam size_t  BEAT_SIZE   = 3'd2;
   localparam burst_t BURST_INCR  = 2'd1;
   // normal access, no exclusive or locked
   localparam lock_t  LOCK_NORMAL = '0;
   // device non-bufferable
   localparam cache_t CACHE_NONE  = '0;
   // unprivileged secure data access
   localparam prot_t  PROT_NONE   = '0;
   localparam resp_t  RESP_OKAY   = 2'b00;

   // shared by AR and AW
   typedef struct packed {
      id_t    id;
      addr_t  addr;
      len_t   len;
      size_t  size;
      burst_t burst;
      lock_t  lock;
      cache_t cache;
      prot_t  prot;
   } axi_addr_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      id_t   id;
      data_t data;
      resp_t resp;
      logic  last;
   } axi_r_t;

   typedef struct packed {
      id_t   id;
      resp_t resp;
   } axi_b_t;

endpackage
